// File: common/io_select_if.sv
`timescale 1ns/100ps
`default_nettype none

interface io_select_if;

   // All active low
   logic dma_cs_n;
   logic intr_cs_n;
   logic tc_cs_n;
   logic ppi_cs_n;
   logic page_wr_n;   // DMA page register write
   logic nmi_wr_n;    // NMI mask register write

   modport decoder (
      output dma_cs_n,
      output intr_cs_n,
      output tc_cs_n,
      output ppi_cs_n,
      output page_wr_n,
      output nmi_wr_n
   );

   // Register blocks only look at the write strobes
   modport sink (
      input page_wr_n,
      input nmi_wr_n
   );

endinterface

`default_nettype wire

// File: common/system_board_params.svh
`ifndef SYSTEM_BOARD_PARAMS_SVH
`define SYSTEM_BOARD_PARAMS_SVH

// Top address nibble of the BIOS ROM area
`define ROM_SEGMENT 4'hF

// Wait states added to each I/O command
`define IO_WAIT_CYCLES 2

// Data bit written to port 0A0h
`define NMI_ENABLE_BIT 7

// I/O blocks picked by address bits 7 to 5
`define IO_BLOCK_DMA   3'd0
`define IO_BLOCK_INTR  3'd1
`define IO_BLOCK_TIMER 3'd2
`define IO_BLOCK_PPI   3'd3
`define IO_BLOCK_PAGE  3'd4
`define IO_BLOCK_NMI   3'd5

// Entries in the DMA page register file
`define PAGE_ENTRIES 4

`endif

// File: common/system_board_pkg.sv
`default_nettype none

package system_board_pkg;

   // 20-bit system address
   typedef logic [19:0] addr_t;

   // System data bus
   typedef logic [7:0] data_t;

   // One active-low strobe per 64K RAM bank
   typedef logic [3:0] bank_vec_t;

   // Active-low ROM chip selects
   typedef logic [7:0] rom_cs_t;

   typedef logic [3:0] page_t;   // Address bits 19 to 16 for DMA

   typedef logic [2:0] status_t; // Active-low CPU S2..S0

   // DRAM strobe sequencer
   typedef enum logic [1:0] {
      DRAM_IDLE = 2'd0,
      DRAM_RAS  = 2'd1,
      DRAM_MUX  = 2'd2,
      DRAM_CAS  = 2'd3
   } dram_state_e;

endpackage

`default_nettype wire

// File: decode/io_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "system_board_params.svh"

module io_decode (
   input  wire system_board_pkg::addr_t a_i,
   input  wire logic                    aen_i,
   input  wire logic                    iow_n_i,
   io_select_if.decoder                 sel
);

   logic       io_space;   // Board range 000h-0FFh while the CPU owns the bus
   logic [2:0] io_block;

   assign io_space = !aen_i && (a_i[9:8] == 2'b00);
   assign io_block = a_i[7:5];   // 32-byte blocks

   always_comb begin
      sel.dma_cs_n  = 1'b1;
      sel.intr_cs_n = 1'b1;
      sel.tc_cs_n   = 1'b1;
      sel.ppi_cs_n  = 1'b1;
      sel.page_wr_n = 1'b1;
      sel.nmi_wr_n  = 1'b1;

      if (io_space) begin
         case (io_block)
            `IO_BLOCK_DMA:   sel.dma_cs_n  = 1'b0;
            `IO_BLOCK_INTR:  sel.intr_cs_n = 1'b0;
            `IO_BLOCK_TIMER: sel.tc_cs_n   = 1'b0;
            `IO_BLOCK_PPI:   sel.ppi_cs_n  = 1'b0;
            // Write-only registers whose strobe follows IOW
            `IO_BLOCK_PAGE:  sel.page_wr_n = iow_n_i;
            `IO_BLOCK_NMI:   sel.nmi_wr_n  = iow_n_i;
            default: begin
               // Blocks 6 and 7 unused on the board
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: decode/mem_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "system_board_params.svh"

module mem_decode (
   input  wire logic                      clk,
   input  wire logic                      reset_n,
   input  wire system_board_pkg::addr_t   a_i,
   input  wire logic                      memr_n_i,
   input  wire logic                      memw_n_i,
   input  wire logic                      dack0_n_i,
   output system_board_pkg::rom_cs_t      rom_cs_n_o,
   output system_board_pkg::bank_vec_t    ras_n_o,
   output system_board_pkg::bank_vec_t    cas_n_o,
   output logic                           addr_sel_o
);

   import system_board_pkg::*;

   dram_state_e state;
   logic        mem_cmd;
   logic        ram_hit;
   logic        refresh;
   logic [1:0]  bank_q;      // Bank of the running access
   logic        refresh_q;
   bank_vec_t   bank_n;

   // One ROM select per 8K chip in the top segment
   always_comb begin
      rom_cs_n_o = '1;
      if ((a_i[19:16] == `ROM_SEGMENT) && !memr_n_i) begin
         rom_cs_n_o[a_i[15:13]] = 1'b0;
      end
   end

   assign mem_cmd = !memr_n_i || !memw_n_i;
   assign ram_hit = (a_i[19:18] == 2'b00);   // Lower 256K
   assign refresh = !memr_n_i && !dack0_n_i; // DMA channel 0 read

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= DRAM_IDLE;
      end else begin
         case (state)
            DRAM_IDLE: if (mem_cmd && (ram_hit || refresh)) state <= DRAM_RAS;
            DRAM_RAS: begin
               if (!mem_cmd) state <= DRAM_IDLE;
               else if (!refresh_q) state <= DRAM_MUX; // Refresh is RAS only
            end
            DRAM_MUX: state <= mem_cmd ? DRAM_CAS : DRAM_IDLE;
            DRAM_CAS: if (!mem_cmd) state <= DRAM_IDLE;
            default: state <= DRAM_IDLE;
         endcase
      end
   end

   // Captured when the access starts
   always_ff @(posedge clk) begin
      if (state == DRAM_IDLE) begin
         bank_q    <= a_i[17:16];
         refresh_q <= refresh;
      end
   end

   assign bank_n = ~(4'b0001 << bank_q);

   always_comb begin
      ras_n_o    = '1;
      cas_n_o    = '1;
      addr_sel_o = 1'b0;
      if (state != DRAM_IDLE) begin
         ras_n_o = refresh_q ? '0 : bank_n;   // Refresh hits every bank
      end
      if (state == DRAM_MUX || state == DRAM_CAS) addr_sel_o = 1'b1; // Column address
      if (state == DRAM_CAS) cas_n_o = bank_n;
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the system board testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f system_board.f \
   --top-module tb_system_board -o tb_system_board
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_system_board > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
   exit 0
fi
exit 1

// File: system_board.f
+incdir+common
common/system_board_pkg.sv
common/io_select_if.sv
decode/io_decode.sv
decode/mem_decode.sv
verilog/bus_arbiter.sv
verilog/nmi_control.sv
verilog/dma_page_reg.sv
verilog/system_board.sv
test/system_board_assertions.sv
test/tb_system_board.sv

// File: test/system_board_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module system_board_assertions (
   input wire logic                        clk,
   input wire logic                        reset_n,
   input wire system_board_pkg::bank_vec_t ras_n_o,
   input wire system_board_pkg::bank_vec_t cas_n_o,
   input wire logic                        aen_o,
   input wire logic                        dma_aen_o,
   input wire logic                        dma_cs_n_o,
   input wire logic                        intr_cs_n_o,
   input wire logic                        tc_cs_n_o,
   input wire logic                        ppi_cs_n_o
);

   // A bank sees CAS only while its RAS is low
   cas_needs_ras: assert property (@(posedge clk) disable iff (!reset_n)
      (~cas_n_o & ras_n_o) == 4'b0000)
      else $error("CAS low on a bank whose RAS is high");

   dma_aen_needs_aen: assert property (@(posedge clk) disable iff (!reset_n)
      dma_aen_o |-> aen_o)
      else $error("DMA address enable high without AEN");

   // Three or more of the four selects stay high
   one_chip_select: assert property (@(posedge clk) disable iff (!reset_n)
      $countones({dma_cs_n_o, intr_cs_n_o, tc_cs_n_o, ppi_cs_n_o}) >= 3)
      else $error("More than one I/O chip select low");

endmodule

bind system_board system_board_assertions u_assertions (.*);

`default_nettype wire

// File: test/tb_system_board.sv
`timescale 1ns/100ps
`default_nettype none

`include "system_board_params.svh"

module tb_system_board;

   import system_board_pkg::*;

   localparam int TEST_CYCLES = 300;
   localparam int TIMEOUT_NS  = TEST_CYCLES * 4 * 2;   // Twice the expected run

   logic      clk;
   logic      reset_n;
   addr_t     a_i;
   data_t     d_i;
   logic      ior_n_i, iow_n_i, memr_n_i, memw_n_i;
   status_t   s_n_i;
   logic      lock_n_i, hrq_i;
   bank_vec_t dack_n_i;
   logic      io_ch_ck_n_i, enable_io_ck_n_i, pck_n_i;
   logic      dma_cs_n_o, intr_cs_n_o, tc_cs_n_o, ppi_cs_n_o;
   rom_cs_t   rom_cs_n_o;
   bank_vec_t ras_n_o, cas_n_o;
   logic      addr_sel_o, ready_o, holda_o, aen_o, dma_aen_o, nmi_o;
   page_t     dma_page_o;

   // Expected registered state
   bank_vec_t exp_ras, exp_cas;
   logic      exp_sel, exp_ready, exp_holda, exp_aen, exp_dma_aen, exp_nmi, exp_mask;
   page_t     exp_pages [4];
   logic      checking;
   int        errors;
   logic [15:0] lfsr;

   system_board uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout, the tests did not finish in time");
      $display("TEST FAIL");
      $finish;
   end

   // Galois LFSR stepped once per bit
   function automatic logic [19:0] rand_bits(input int n);
      logic [19:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v = {v[18:0], lfsr[0]};
      end
      return v;
   endfunction

   // Active-low selects packed as {dma, intr, tc, ppi, rom[7:0]}
   function automatic logic [11:0] ref_outputs(input addr_t addr, input logic aen,
                                               input logic memr_n);
      logic [3:0] cs_n;
      logic [7:0] rom_n;
      cs_n  = 4'hF;
      rom_n = 8'hFF;
      if (!aen && addr[9:8] == 2'b00 && addr[7:5] < 3'd4) cs_n[3 - addr[7:5]] = 1'b0;
      if (addr[19:16] == `ROM_SEGMENT && !memr_n) rom_n[addr[15:13]] = 1'b0;
      return {cs_n, rom_n};
   endfunction

   // Page entry read back for the acknowledged DMA channel
   function automatic logic [1:0] page_entry(input bank_vec_t dack_n);
      logic [1:0] idx;
      idx = 2'd3;
      if (!dack_n[2] && !dack_n[3]) begin
         idx = 2'd0;   // Both channels acknowledged
      end else if (!dack_n[2]) begin
         idx = 2'd1;
      end else if (!dack_n[3]) begin
         idx = 2'd2;
      end
      return idx;
   endfunction

   task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   always @(negedge clk) begin : compare
      logic [11:0] exp_c;
      page_t       exp_page;
      if (checking) begin
         exp_c    = ref_outputs(a_i, exp_aen, memr_n_i);
         exp_page = exp_dma_aen ? exp_pages[page_entry(dack_n_i)] : 4'h0;
         check("dma_cs_n_o", 8'(dma_cs_n_o), 8'(exp_c[11]));
         check("intr_cs_n_o", 8'(intr_cs_n_o), 8'(exp_c[10]));
         check("tc_cs_n_o", 8'(tc_cs_n_o), 8'(exp_c[9]));
         check("ppi_cs_n_o", 8'(ppi_cs_n_o), 8'(exp_c[8]));
         check("rom_cs_n_o", rom_cs_n_o, exp_c[7:0]);
         check("ras_n_o", 8'(ras_n_o), 8'(exp_ras));
         check("cas_n_o", 8'(cas_n_o), 8'(exp_cas));
         check("addr_sel_o", 8'(addr_sel_o), 8'(exp_sel));
         check("ready_o", 8'(ready_o), 8'(exp_ready));
         check("holda_o", 8'(holda_o), 8'(exp_holda));
         check("aen_o", 8'(aen_o), 8'(exp_aen));
         check("dma_aen_o", 8'(dma_aen_o), 8'(exp_dma_aen));
         check("dma_page_o", 8'(dma_page_o), 8'(exp_page));
         check("nmi_o", 8'(nmi_o), 8'(exp_nmi));
      end
   end

   // One I/O read or write with its two wait states
   task automatic io_cycle(input addr_t addr, input data_t data, input logic wr);
      logic hit;
      hit = wr && !exp_aen && addr[9:8] == 2'b00;
      @(posedge clk);
      a_i <= addr;
      d_i <= data;
      if (wr) iow_n_i <= 1'b0;
      else ior_n_i <= 1'b0;
      @(posedge clk);
      exp_ready = 1'b0;
      if (hit && addr[7:5] == `IO_BLOCK_PAGE) exp_pages[addr[1:0]] = data[3:0];
      if (hit && addr[7:5] == `IO_BLOCK_NMI) exp_mask = data[`NMI_ENABLE_BIT];
      exp_nmi = exp_mask && !pck_n_i;
      @(posedge clk);
      iow_n_i <= 1'b1;
      ior_n_i <= 1'b1;
      @(posedge clk);
      exp_ready = 1'b1;
   endtask

   // Memory command held through the whole RAS, MUX, CAS sequence
   task automatic mem_cycle(input addr_t addr, input logic wr, input logic refresh);
      logic      ram;
      bank_vec_t bank_n;
      ram    = addr[19:18] == 2'b00 || refresh;
      bank_n = ~(4'b0001 << addr[17:16]);
      @(posedge clk);
      a_i <= addr;
      if (wr) memw_n_i <= 1'b0;
      else memr_n_i <= 1'b0;
      dack_n_i[0] <= !refresh;
      @(posedge clk);
      if (ram) exp_ras = refresh ? 4'h0 : bank_n;
      @(posedge clk);
      if (ram && !refresh) exp_sel = 1'b1;
      @(posedge clk);
      if (ram && !refresh) exp_cas = bank_n;
      @(posedge clk);
      memr_n_i    <= 1'b1;
      memw_n_i    <= 1'b1;
      dack_n_i[0] <= 1'b1;
      @(posedge clk);
      exp_ras = 4'hF;
      exp_cas = 4'hF;
      exp_sel = 1'b0;
   endtask

   initial begin
      reset_n = 1'b0;
      a_i = '0;
      d_i = '0;
      ior_n_i = 1'b1;
      iow_n_i = 1'b1;
      memr_n_i = 1'b1;
      memw_n_i = 1'b1;
      s_n_i = 3'b111;
      lock_n_i = 1'b1;
      hrq_i = 1'b0;
      dack_n_i = 4'hF;
      io_ch_ck_n_i = 1'b1;
      enable_io_ck_n_i = 1'b1;
      pck_n_i = 1'b1;
      exp_ras = 4'hF;
      exp_cas = 4'hF;
      {exp_sel, exp_holda, exp_aen, exp_dma_aen, exp_nmi, exp_mask} = '0;
      exp_ready = 1'b1;
      for (int i = 0; i < 4; i++) exp_pages[i] = 4'h0;
      checking = 1'b0;
      errors = 0;
      lfsr = 16'd8626;
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      checking = 1'b1;

      for (int i = 0; i < 16; i++) begin
         io_cycle(20'(rand_bits(10)), 8'(rand_bits(8)), rand_bits(1) != 0);
      end
      for (int i = 0; i < 4; i++) io_cycle(20'h00080 + 20'(i), 8'(rand_bits(8)), 1'b1);

      for (int b = 0; b < 4; b++) begin
         mem_cycle({2'b00, 2'(b), 16'(rand_bits(16))}, 1'b0, 1'b0);
         mem_cycle({2'b00, 2'(b), 16'(rand_bits(16))}, 1'b1, 1'b0);
      end
      for (int i = 0; i < 4; i++) mem_cycle({4'hF, 16'(rand_bits(16))}, 1'b0, 1'b0);
      for (int i = 0; i < 2; i++) mem_cycle({4'h0, 16'(rand_bits(16))}, 1'b0, 1'b1);

      // Busy status and then LOCK keep the hold off
      @(posedge clk);
      hrq_i <= 1'b1;
      s_n_i <= 3'b100;
      repeat (3) @(posedge clk);
      s_n_i    <= 3'b111;
      lock_n_i <= 1'b0;
      repeat (3) @(posedge clk);
      lock_n_i <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      exp_holda = 1'b1;
      @(posedge clk);
      exp_aen = 1'b1;
      @(posedge clk);
      exp_dma_aen = 1'b1;
      // Each board block is addressed while AEN is high
      for (int i = 0; i < 6; i++) begin
         io_cycle({12'h000, 3'(i), 5'(rand_bits(5))}, 8'(rand_bits(8)), 1'b1);
      end
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         dack_n_i <= {2'(i), 2'b11};   // Walks DACK3 and DACK2
      end
      @(posedge clk);
      hrq_i    <= 1'b0;
      dack_n_i <= 4'hF;
      @(posedge clk);
      exp_holda = 1'b0;
      @(posedge clk);
      exp_aen     = 1'b0;
      exp_dma_aen = 1'b0;

      io_cycle(20'h000A0, 8'h80, 1'b1);   // Mask on with no source yet
      @(posedge clk);
      pck_n_i <= 1'b0;
      @(posedge clk);
      exp_nmi = 1'b1;
      @(posedge clk);
      pck_n_i <= 1'b1;
      @(posedge clk);
      exp_nmi = 1'b0;
      @(posedge clk);
      enable_io_ck_n_i <= 1'b0;
      io_ch_ck_n_i     <= 1'b0;
      @(posedge clk);
      exp_nmi = 1'b1;
      @(posedge clk);
      io_ch_ck_n_i <= 1'b1;   // Latch keeps NMI up
      repeat (2) @(posedge clk);
      enable_io_ck_n_i <= 1'b1;
      @(posedge clk);
      exp_nmi = 1'b0;
      @(posedge clk);
      pck_n_i <= 1'b0;
      @(posedge clk);
      exp_nmi = 1'b1;
      io_cycle(20'h000A0, 8'h00, 1'b1);   // Mask off hides the parity error
      @(posedge clk);
      pck_n_i <= 1'b1;
      repeat (2) @(posedge clk);

      checking = 1'b0;
      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/bus_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "system_board_params.svh"

module bus_arbiter (
   input  wire logic                    clk,
   input  wire logic                    reset_n,
   input  wire system_board_pkg::status_t s_n_i,
   input  wire logic                    lock_n_i,
   input  wire logic                    hrq_i,
   input  wire logic                    ior_n_i,
   input  wire logic                    iow_n_i,
   output logic                         holda_o,
   output logic                         aen_o,
   output logic                         dma_aen_o,
   output logic                         ready_o
);

   logic       bus_idle;    // Passive status and no LOCK
   logic       hold_req_q;
   logic       io_idle_q;   // Both I/O strobes high last cycle
   logic       io_start;
   logic [1:0] wait_cnt;

   assign bus_idle = (&s_n_i) && lock_n_i;

   // Hold request and acknowledge chain
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         hold_req_q <= 1'b0;
         holda_o    <= 1'b0;
         aen_o      <= 1'b0;
         dma_aen_o  <= 1'b0;
      end else begin
         hold_req_q <= hrq_i && bus_idle;
         if (!hrq_i) begin
            holda_o <= 1'b0;              // Drop as soon as DMA lets go
         end else if (hold_req_q) begin
            holda_o <= 1'b1;
         end
         aen_o     <= holda_o;
         dma_aen_o <= aen_o && holda_o;  // Falls together with aen
      end
   end

   // New I/O command seen when a strobe drops
   assign io_start = io_idle_q && (!ior_n_i || !iow_n_i);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         io_idle_q <= 1'b1;
         wait_cnt  <= 2'd0;
      end else begin
         io_idle_q <= ior_n_i && iow_n_i;
         if (io_start) begin
            wait_cnt <= 2'(`IO_WAIT_CYCLES);
         end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

   assign ready_o = (wait_cnt == 2'd0);   // Low while wait states run

endmodule

`default_nettype wire

// File: verilog/dma_page_reg.sv
`timescale 1ns/100ps
`default_nettype none

`include "system_board_params.svh"

module dma_page_reg (
   input  wire logic                      clk,
   input  wire logic                      reset_n,
   input  wire system_board_pkg::addr_t   a_i,
   input  wire system_board_pkg::data_t   d_i,
   io_select_if.sink                      sel,
   input  wire system_board_pkg::bank_vec_t dack_n_i,
   input  wire logic                      dma_aen_i,
   output system_board_pkg::page_t        page_o
);

   import system_board_pkg::*;

   page_t      pages [`PAGE_ENTRIES];
   logic [1:0] wr_idx;
   logic [1:0] rd_idx;

   assign wr_idx = a_i[1:0];   // Ports 080h-083h

   // Channels 0 and 1 share entry 3
   assign rd_idx = {dack_n_i[2], dack_n_i[3]};

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < `PAGE_ENTRIES; i++) begin
            pages[i] <= '0;
         end
      end else if (!sel.page_wr_n) begin
         pages[wr_idx] <= d_i[3:0];
      end
   end

   // Drives A19-A16 only during DMA cycles
   assign page_o = dma_aen_i ? pages[rd_idx] : '0;

endmodule

`default_nettype wire

// File: verilog/nmi_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "system_board_params.svh"

module nmi_control (
   input  wire logic                  clk,
   input  wire logic                  reset_n,
   input  wire system_board_pkg::data_t d_i,
   io_select_if.sink                  sel,
   input  wire logic                  io_ch_ck_n_i,
   input  wire logic                  enable_io_ck_n_i,
   input  wire logic                  pck_n_i,
   output logic                       nmi_o
);

   logic mask_q;       // NMI allowed
   logic mask_nxt;
   logic io_ck_q;      // Channel check latch
   logic io_ck_nxt;

   assign mask_nxt = !sel.nmi_wr_n ? d_i[`NMI_ENABLE_BIT] : mask_q;

   // Held until software disables checking
   assign io_ck_nxt = !enable_io_ck_n_i && (io_ck_q || !io_ch_ck_n_i);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         mask_q  <= 1'b0;
         io_ck_q <= 1'b0;
         nmi_o   <= 1'b0;
      end else begin
         mask_q  <= mask_nxt;
         io_ck_q <= io_ck_nxt;
         nmi_o   <= mask_nxt && (!pck_n_i || io_ck_nxt); // Parity or channel error
      end
   end

endmodule

`default_nettype wire

// File: verilog/system_board.sv
`timescale 1ns/100ps
`default_nettype none

module system_board (
   input  wire logic                        clk,
   input  wire logic                        reset_n,
   input  wire system_board_pkg::addr_t     a_i,
   input  wire system_board_pkg::data_t     d_i,
   input  wire logic                        ior_n_i,
   input  wire logic                        iow_n_i,
   input  wire logic                        memr_n_i,
   input  wire logic                        memw_n_i,
   input  wire system_board_pkg::status_t   s_n_i,
   input  wire logic                        lock_n_i,
   input  wire logic                        hrq_i,
   input  wire system_board_pkg::bank_vec_t dack_n_i,
   input  wire logic                        io_ch_ck_n_i,
   input  wire logic                        enable_io_ck_n_i,
   input  wire logic                        pck_n_i,
   output logic                             dma_cs_n_o,
   output logic                             intr_cs_n_o,
   output logic                             tc_cs_n_o,
   output logic                             ppi_cs_n_o,
   output system_board_pkg::rom_cs_t        rom_cs_n_o,
   output system_board_pkg::bank_vec_t      ras_n_o,
   output system_board_pkg::bank_vec_t      cas_n_o,
   output logic                             addr_sel_o,
   output logic                             ready_o,
   output logic                             holda_o,
   output logic                             aen_o,
   output logic                             dma_aen_o,
   output system_board_pkg::page_t          dma_page_o,
   output logic                             nmi_o
);

   io_select_if sel_if ();

   // Peripheral chip selects go off board
   assign dma_cs_n_o  = sel_if.dma_cs_n;
   assign intr_cs_n_o = sel_if.intr_cs_n;
   assign tc_cs_n_o   = sel_if.tc_cs_n;
   assign ppi_cs_n_o  = sel_if.ppi_cs_n;

   io_decode u_io_decode (
      .a_i     (a_i),
      .aen_i   (aen_o),
      .iow_n_i (iow_n_i),
      .sel     (sel_if)
   );

   mem_decode u_mem_decode (
      .clk        (clk),
      .reset_n    (reset_n),
      .a_i        (a_i),
      .memr_n_i   (memr_n_i),
      .memw_n_i   (memw_n_i),
      .dack0_n_i  (dack_n_i[0]),   // Refresh channel
      .rom_cs_n_o (rom_cs_n_o),
      .ras_n_o    (ras_n_o),
      .cas_n_o    (cas_n_o),
      .addr_sel_o (addr_sel_o)
   );

   bus_arbiter u_bus_arbiter (
      .clk       (clk),
      .reset_n   (reset_n),
      .s_n_i     (s_n_i),
      .lock_n_i  (lock_n_i),
      .hrq_i     (hrq_i),
      .ior_n_i   (ior_n_i),
      .iow_n_i   (iow_n_i),
      .holda_o   (holda_o),
      .aen_o     (aen_o),
      .dma_aen_o (dma_aen_o),
      .ready_o   (ready_o)
   );

   nmi_control u_nmi_control (
      .clk              (clk),
      .reset_n          (reset_n),
      .d_i              (d_i),
      .sel              (sel_if),
      .io_ch_ck_n_i     (io_ch_ck_n_i),
      .enable_io_ck_n_i (enable_io_ck_n_i),
      .pck_n_i          (pck_n_i),
      .nmi_o            (nmi_o)
   );

   dma_page_reg u_dma_page_reg (
      .clk       (clk),
      .reset_n   (reset_n),
      .a_i       (a_i),
      .d_i       (d_i),
      .sel       (sel_if),
      .dack_n_i  (dack_n_i),
      .dma_aen_i (dma_aen_o),
      .page_o    (dma_page_o)
   );

endmodule

`default_nettype wire
